//--- rtl/rn_pkg.sv
// shared widths, sizes and vector types for the integer rename unit, referenced as rn_pkg::name
`default_nettype none

package rn_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int LANES       = 2;   // instructions per rename group
  localparam int ARCH_REGS   = 32;
  localparam int PHYS_REGS   = 64;
  localparam int ARCH_W      = $clog2(ARCH_REGS);
  localparam int RNID_W      = $clog2(PHYS_REGS);
  localparam int SRC_PORTS   = 2 * LANES;  // rs1 and rs2 per lane

  // per-lane free list, deep enough to take every physical id
  localparam int FLIST_DEPTH = 32;
  localparam int FLIST_INIT  = 16;  // ids loaded at reset
  localparam int FLIST_PTR_W = $clog2(FLIST_DEPTH);
  localparam int FLIST_CNT_W = $clog2(FLIST_DEPTH + 1);

  // --------------------
  // types
  // --------------------
  typedef logic [ARCH_W-1:0]      arch_t;
  typedef logic [RNID_W-1:0]      rnid_t;
  typedef logic [LANES-1:0]       lane_mask_t;
  typedef logic [FLIST_PTR_W-1:0] flist_ptr_t;
  typedef logic [FLIST_CNT_W-1:0] flist_cnt_t;

endpackage

`default_nettype wire

//--- rtl/rn_retire_if.sv
// delayed retire group from the retire stage to free lists, commit map and map table
`timescale 1ns/100ps
`default_nettype none

interface rn_retire_if ();

  rn_pkg::lane_mask_t                   push;      // free-list return per lane
  rn_pkg::rnid_t [rn_pkg::LANES-1:0]    push_id;
  rn_pkg::lane_mask_t                   commit_wr; // committed map update per lane
  rn_pkg::arch_t [rn_pkg::LANES-1:0]    arch;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0]    new_rnid;
  logic                                 restore;   // whole group, flush seen

  modport stage (
    output push, push_id, commit_wr, arch, new_rnid, restore
  );

  modport sink (
    input push, push_id, commit_wr, arch, new_rnid, restore
  );

endinterface

`default_nettype wire

//--- rtl/rn_freelist.sv
// circular FIFO of free physical ids for one rename lane, preloaded from BASE at reset
`timescale 1ns/100ps
`default_nettype none

module rn_freelist #(
  parameter rn_pkg::rnid_t BASE = '0
) (
  input  logic          i_clk,
  input  logic          i_reset_n,
  input  logic          i_pop,
  output rn_pkg::rnid_t o_pop_id,
  input  logic          i_push,
  input  rn_pkg::rnid_t i_push_id,
  output logic          o_empty
);

  rn_pkg::rnid_t      r_mem [rn_pkg::FLIST_DEPTH];
  rn_pkg::flist_ptr_t r_rd_ptr;
  rn_pkg::flist_ptr_t r_wr_ptr;
  rn_pkg::flist_cnt_t r_count;

  assign o_pop_id = r_mem[r_rd_ptr];  // head is visible before the pop
  assign o_empty  = (r_count == '0);

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < rn_pkg::FLIST_DEPTH; i++) begin
        r_mem[i] <= (i < rn_pkg::FLIST_INIT) ? rn_pkg::rnid_t'(BASE + i) : '0;
      end
    end else if (i_push) begin
      r_mem[r_wr_ptr] <= i_push_id;
    end
  end

  // --------------------
  // pointers and count
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rd_ptr <= '0;
      r_wr_ptr <= rn_pkg::flist_ptr_t'(rn_pkg::FLIST_INIT);
      r_count  <= rn_pkg::flist_cnt_t'(rn_pkg::FLIST_INIT);
    end else begin
      if (i_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;  // wraps at depth
      end
      if (i_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // none, or push and pop together
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/rn_map_table.sv
// speculative arch-to-physical map, combinational reads, in-order writes and bulk restore
`timescale 1ns/100ps
`default_nettype none

module rn_map_table (
  input  logic                                     i_clk,
  input  logic                                     i_reset_n,
  input  rn_pkg::arch_t [rn_pkg::SRC_PORTS-1:0]    i_rs_arch,
  output rn_pkg::rnid_t [rn_pkg::SRC_PORTS-1:0]    o_rs_rnid,
  input  rn_pkg::arch_t [rn_pkg::LANES-1:0]        i_rd_arch,
  output rn_pkg::rnid_t [rn_pkg::LANES-1:0]        o_rd_old_rnid,
  input  rn_pkg::lane_mask_t                       i_wr,
  input  rn_pkg::rnid_t [rn_pkg::LANES-1:0]        i_wr_rnid,
  input  rn_pkg::rnid_t [rn_pkg::ARCH_REGS-1:0]    i_restore_map,
  rn_retire_if.sink                                retire
);

  rn_pkg::rnid_t r_map [rn_pkg::ARCH_REGS];

  always_comb begin
    for (int p = 0; p < rn_pkg::SRC_PORTS; p++) begin
      o_rs_rnid[p] = r_map[i_rs_arch[p]];
    end
    for (int l = 0; l < rn_pkg::LANES; l++) begin
      o_rd_old_rnid[l] = r_map[i_rd_arch[l]];  // before this group's writes
    end
  end

  // lanes are walked oldest first so the younger write lands last
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int a = 0; a < rn_pkg::ARCH_REGS; a++) begin
        r_map[a] <= rn_pkg::rnid_t'(a);  // identity
      end
    end else if (retire.restore) begin
      for (int a = 0; a < rn_pkg::ARCH_REGS; a++) begin
        r_map[a] <= i_restore_map[a];
      end
      // commits retiring alongside the flush are not in the commit map yet
      for (int l = 0; l < rn_pkg::LANES; l++) begin
        if (retire.commit_wr[l]) begin
          r_map[retire.arch[l]] <= retire.new_rnid[l];
        end
      end
    end else begin
      for (int l = 0; l < rn_pkg::LANES; l++) begin
        if (i_wr[l]) begin
          r_map[i_rd_arch[l]] <= i_wr_rnid[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/rn_commit_map.sv
// committed arch-to-physical map, updated by normal commits, source for flush restore
`timescale 1ns/100ps
`default_nettype none

module rn_commit_map (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,
  rn_retire_if.sink                             retire,
  output rn_pkg::rnid_t [rn_pkg::ARCH_REGS-1:0] o_map
);

  rn_pkg::rnid_t [rn_pkg::ARCH_REGS-1:0] r_map;

  assign o_map = r_map;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int a = 0; a < rn_pkg::ARCH_REGS; a++) begin
        r_map[a] <= rn_pkg::rnid_t'(a);
      end
    end else begin
      for (int l = 0; l < rn_pkg::LANES; l++) begin  // younger lane last
        if (retire.commit_wr[l]) begin
          r_map[retire.arch[l]] <= retire.new_rnid[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/rn_retire_stage.sv
// registers the retire group and picks the id each lane gives back to its free list
`timescale 1ns/100ps
`default_nettype none

module rn_retire_stage (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  rn_pkg::lane_mask_t                i_cmt_valid,
  input  rn_pkg::lane_mask_t                i_cmt_flush,
  input  rn_pkg::lane_mask_t                i_cmt_dead,
  input  rn_pkg::lane_mask_t                i_cmt_rd_valid,
  input  rn_pkg::arch_t [rn_pkg::LANES-1:0] i_cmt_rd_arch,
  input  rn_pkg::rnid_t [rn_pkg::LANES-1:0] i_cmt_rd_rnid,
  input  rn_pkg::rnid_t [rn_pkg::LANES-1:0] i_cmt_old_rnid,
  rn_retire_if.stage                        retire
);

  rn_pkg::lane_mask_t                r_valid;
  rn_pkg::lane_mask_t                r_flush;
  rn_pkg::lane_mask_t                r_dead;
  rn_pkg::lane_mask_t                r_rd_valid;
  rn_pkg::arch_t [rn_pkg::LANES-1:0] r_arch;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] r_rnid;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] r_old_rnid;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid    <= '0;
      r_flush    <= '0;
      r_dead     <= '0;
      r_rd_valid <= '0;
    end else begin
      r_valid    <= i_cmt_valid;
      r_flush    <= i_cmt_flush;
      r_dead     <= i_cmt_dead;
      r_rd_valid <= i_cmt_rd_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_arch     <= i_cmt_rd_arch;
    r_rnid     <= i_cmt_rd_rnid;
    r_old_rnid <= i_cmt_old_rnid;
  end

  // --------------------
  // per-lane return
  // --------------------
  //   commit         old id back, commit map written
  //   dead or flush  new id back, no commit map write
  always_comb begin
    for (int l = 0; l < rn_pkg::LANES; l++) begin
      retire.push[l]      = r_valid[l] & r_rd_valid[l] & (r_arch[l] != '0);
      retire.push_id[l]   = (r_dead[l] | r_flush[l]) ? r_rnid[l] : r_old_rnid[l];
      retire.commit_wr[l] = retire.push[l] & ~r_dead[l] & ~r_flush[l];
    end
  end

  assign retire.arch     = r_arch;
  assign retire.new_rnid = r_rnid;
  assign retire.restore  = |(r_valid & r_flush);

endmodule

`default_nettype wire

//--- rtl/rn_group_bypass.sv
// forwards new destination ids from older lanes to younger lanes of the same group
`timescale 1ns/100ps
`default_nettype none

module rn_group_bypass (
  input  rn_pkg::arch_t [rn_pkg::LANES-1:0] i_rs1_arch,
  input  rn_pkg::arch_t [rn_pkg::LANES-1:0] i_rs2_arch,
  input  rn_pkg::arch_t [rn_pkg::LANES-1:0] i_rd_arch,
  input  rn_pkg::lane_mask_t                i_alloc,
  input  rn_pkg::rnid_t [rn_pkg::LANES-1:0] i_new_rnid,
  input  rn_pkg::rnid_t [rn_pkg::LANES-1:0] i_map_rs1,
  input  rn_pkg::rnid_t [rn_pkg::LANES-1:0] i_map_rs2,
  input  rn_pkg::rnid_t [rn_pkg::LANES-1:0] i_map_old,
  output rn_pkg::rnid_t [rn_pkg::LANES-1:0] o_rs1_rnid,
  output rn_pkg::rnid_t [rn_pkg::LANES-1:0] o_rs2_rnid,
  output rn_pkg::rnid_t [rn_pkg::LANES-1:0] o_rd_old_rnid
);

  // older lanes scanned oldest first, so the youngest match overrides
  always_comb begin
    for (int d = 0; d < rn_pkg::LANES; d++) begin
      o_rs1_rnid[d]    = i_map_rs1[d];
      o_rs2_rnid[d]    = i_map_rs2[d];
      o_rd_old_rnid[d] = i_map_old[d];
      for (int p = 0; p < d; p++) begin
        if (i_alloc[p] && (i_rd_arch[p] == i_rs1_arch[d])) begin
          o_rs1_rnid[d] = i_new_rnid[p];
        end
        if (i_alloc[p] && (i_rd_arch[p] == i_rs2_arch[d])) begin
          o_rs2_rnid[d] = i_new_rnid[p];
        end
        if (i_alloc[p] && (i_rd_arch[p] == i_rd_arch[d])) begin
          o_rd_old_rnid[d] = i_new_rnid[p];  // waw inside the group
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/rename_unit.sv
// integer register rename unit top, rename path from the front end and retire return path
`timescale 1ns/100ps
`default_nettype none

module rename_unit (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  // front side
  input  logic                              i_front_valid,
  input  rn_pkg::arch_t [rn_pkg::LANES-1:0] i_rs1_arch,
  input  rn_pkg::arch_t [rn_pkg::LANES-1:0] i_rs2_arch,
  input  rn_pkg::lane_mask_t                i_rd_valid,
  input  rn_pkg::arch_t [rn_pkg::LANES-1:0] i_rd_arch,
  output logic                              o_ready,
  // rename results
  output rn_pkg::rnid_t [rn_pkg::LANES-1:0] o_rs1_rnid,
  output rn_pkg::rnid_t [rn_pkg::LANES-1:0] o_rs2_rnid,
  output rn_pkg::rnid_t [rn_pkg::LANES-1:0] o_rd_rnid,
  output rn_pkg::rnid_t [rn_pkg::LANES-1:0] o_rd_old_rnid,
  // retire side
  input  rn_pkg::lane_mask_t                i_cmt_valid,
  input  rn_pkg::lane_mask_t                i_cmt_flush,
  input  rn_pkg::lane_mask_t                i_cmt_dead,
  input  rn_pkg::lane_mask_t                i_cmt_rd_valid,
  input  rn_pkg::arch_t [rn_pkg::LANES-1:0] i_cmt_rd_arch,
  input  rn_pkg::rnid_t [rn_pkg::LANES-1:0] i_cmt_rd_rnid,
  input  rn_pkg::rnid_t [rn_pkg::LANES-1:0] i_cmt_old_rnid
);

  logic                                  w_fire;
  rn_pkg::lane_mask_t                    w_empty;
  rn_pkg::lane_mask_t                    w_alloc;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0]     w_pop_id;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0]     w_new_rnid;
  rn_pkg::arch_t [rn_pkg::SRC_PORTS-1:0] w_rs_arch;
  rn_pkg::rnid_t [rn_pkg::SRC_PORTS-1:0] w_rs_rnid;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0]     w_map_rs1;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0]     w_map_rs2;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0]     w_map_old;
  rn_pkg::rnid_t [rn_pkg::ARCH_REGS-1:0] w_commit_map;

  rn_retire_if retire_if ();

  // stall while any lane is dry or a flush restore is pending
  assign o_ready = ~(|w_empty) & ~retire_if.restore;
  assign w_fire  = i_front_valid & o_ready;

  // --------------------
  // per-lane allocation
  // --------------------
  for (genvar d = 0; d < rn_pkg::LANES; d++) begin : g_lane
    assign w_alloc[d]    = w_fire & i_rd_valid[d] & (i_rd_arch[d] != '0);  // x0 never renamed
    assign w_new_rnid[d] = w_alloc[d] ? w_pop_id[d] : '0;

    // map read ports, rs1 then rs2 for each lane
    assign w_rs_arch[2*d]   = i_rs1_arch[d];
    assign w_rs_arch[2*d+1] = i_rs2_arch[d];
    assign w_map_rs1[d]     = w_rs_rnid[2*d];
    assign w_map_rs2[d]     = w_rs_rnid[2*d+1];

    rn_freelist #(
      .BASE (rn_pkg::rnid_t'(rn_pkg::ARCH_REGS + rn_pkg::FLIST_INIT * d))
    ) u_freelist (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_pop     (w_alloc[d]),
      .o_pop_id  (w_pop_id[d]),
      .i_push    (retire_if.push[d]),
      .i_push_id (retire_if.push_id[d]),
      .o_empty   (w_empty[d])
    );
  end

  assign o_rd_rnid = w_new_rnid;

  rn_map_table u_map_table (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rs_arch     (w_rs_arch),
    .o_rs_rnid     (w_rs_rnid),
    .i_rd_arch     (i_rd_arch),
    .o_rd_old_rnid (w_map_old),
    .i_wr          (w_alloc),
    .i_wr_rnid     (w_new_rnid),
    .i_restore_map (w_commit_map),
    .retire        (retire_if.sink)
  );

  rn_group_bypass u_group_bypass (
    .i_rs1_arch    (i_rs1_arch),
    .i_rs2_arch    (i_rs2_arch),
    .i_rd_arch     (i_rd_arch),
    .i_alloc       (w_alloc),
    .i_new_rnid    (w_new_rnid),
    .i_map_rs1     (w_map_rs1),
    .i_map_rs2     (w_map_rs2),
    .i_map_old     (w_map_old),
    .o_rs1_rnid    (o_rs1_rnid),
    .o_rs2_rnid    (o_rs2_rnid),
    .o_rd_old_rnid (o_rd_old_rnid)
  );

  // --------------------
  // retire path
  // --------------------
  rn_retire_stage u_retire_stage (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_cmt_valid    (i_cmt_valid),
    .i_cmt_flush    (i_cmt_flush),
    .i_cmt_dead     (i_cmt_dead),
    .i_cmt_rd_valid (i_cmt_rd_valid),
    .i_cmt_rd_arch  (i_cmt_rd_arch),
    .i_cmt_rd_rnid  (i_cmt_rd_rnid),
    .i_cmt_old_rnid (i_cmt_old_rnid),
    .retire         (retire_if.stage)
  );

  rn_commit_map u_commit_map (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .retire    (retire_if.sink),
    .o_map     (w_commit_map)
  );

endmodule

`default_nettype wire

//--- test/rename_unit_props.sv
// concurrent checks on allocation, flush stall and reset-time ids, bound into rename_unit
`timescale 1ns/100ps
`default_nettype none

module rename_unit_props (
  input logic                              i_clk,
  input logic                              i_reset_n,
  input rn_pkg::lane_mask_t                i_alloc,
  input rn_pkg::rnid_t [rn_pkg::LANES-1:0] i_new_rnid,
  input rn_pkg::lane_mask_t                i_cmt_valid,
  input rn_pkg::lane_mask_t                i_cmt_flush,
  input logic                              i_ready
);

  logic [4:0] r_alloc_cnt [rn_pkg::LANES];  // saturates at the preload size
  int         unique_fails = 0;
  int         stall_fails  = 0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int l = 0; l < rn_pkg::LANES; l++) begin
        r_alloc_cnt[l] <= '0;
      end
    end else begin
      for (int l = 0; l < rn_pkg::LANES; l++) begin
        if (i_alloc[l] && (r_alloc_cnt[l] < 5'(rn_pkg::FLIST_INIT))) begin
          r_alloc_cnt[l] <= r_alloc_cnt[l] + 5'd1;
        end
      end
    end
  end

  // --------------------
  // properties
  // --------------------
  a_unique_alloc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (&i_alloc) |-> (i_new_rnid[0] != i_new_rnid[1]))
    else begin
      $error("both lanes allocated physical id %0d", i_new_rnid[0]);
      unique_fails++;
    end

  a_flush_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (|(i_cmt_valid & i_cmt_flush)) |=> !i_ready)
    else begin
      $error("o_ready high in the cycle after a flush");
      stall_fails++;
    end

  for (genvar l = 0; l < rn_pkg::LANES; l++) begin : g_lane
    int preload_fails = 0;
    // preloaded ids all sit above the arch range
    a_preload_ids: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (i_alloc[l] && (r_alloc_cnt[l] < 5'(rn_pkg::FLIST_INIT)))
        |-> (i_new_rnid[l] >= rn_pkg::rnid_t'(rn_pkg::ARCH_REGS)))
      else begin
        $error("lane %0d allocated id %0d from the arch range", l, i_new_rnid[l]);
        preload_fails++;
      end
  end

endmodule

bind rename_unit rename_unit_props u_props (
  .i_clk       (i_clk),
  .i_reset_n   (i_reset_n),
  .i_alloc     (w_alloc),
  .i_new_rnid  (w_new_rnid),
  .i_cmt_valid (i_cmt_valid),
  .i_cmt_flush (i_cmt_flush),
  .i_ready     (o_ready)
);

`default_nettype wire

//--- test/tb_rename_unit.sv
// random-stimulus testbench for rename_unit, checked against a model of maps, free lists and retire
`timescale 1ns/100ps
`default_nettype none

module tb_rename_unit;

  localparam logic [31:0] SEED = 32'h6e4e_d7f3;
  localparam int M_IDENT  = 0;
  localparam int M_FWD    = 1;
  localparam int M_RAND   = 2;
  localparam int M_STARVE = 3;
  localparam int M_DRAIN  = 4;
  localparam int N_IDENT  = 8;
  localparam int N_FWD    = 150;
  localparam int N_RAND   = 400;
  localparam int N_STARVE = 120;
  localparam int N_DRAIN  = 24;
  localparam int TOTAL_CYCLES = 3 + N_IDENT + N_FWD + N_RAND + N_STARVE + N_DRAIN;

  logic                              clk;
  logic                              reset_n;
  logic                              front_valid;
  rn_pkg::arch_t [rn_pkg::LANES-1:0] rs1_arch;
  rn_pkg::arch_t [rn_pkg::LANES-1:0] rs2_arch;
  rn_pkg::lane_mask_t                rd_valid;
  rn_pkg::arch_t [rn_pkg::LANES-1:0] rd_arch;
  logic                              ready;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] rs1_rnid;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] rs2_rnid;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] rd_rnid;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] rd_old_rnid;
  rn_pkg::lane_mask_t                cmt_valid;
  rn_pkg::lane_mask_t                cmt_flush;
  rn_pkg::lane_mask_t                cmt_dead;
  rn_pkg::lane_mask_t                cmt_rd_valid;
  rn_pkg::arch_t [rn_pkg::LANES-1:0] cmt_rd_arch;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] cmt_rd_rnid;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] cmt_old_rnid;

  // --------------------
  // model state
  // --------------------
  rn_pkg::rnid_t spec_map [rn_pkg::ARCH_REGS];
  rn_pkg::rnid_t cmt_map  [rn_pkg::ARCH_REGS];
  rn_pkg::rnid_t free_q   [rn_pkg::LANES][$];
  rn_pkg::arch_t fl_arch  [$];  // in-flight, oldest first
  rn_pkg::rnid_t fl_new   [$];
  rn_pkg::rnid_t fl_old   [$];

  logic                              cur_valid;
  logic                              fired;
  logic                              pending;   // group held under back-pressure
  rn_pkg::arch_t [rn_pkg::LANES-1:0] cur_rs1;
  rn_pkg::arch_t [rn_pkg::LANES-1:0] cur_rs2;
  rn_pkg::arch_t [rn_pkg::LANES-1:0] cur_rd;
  rn_pkg::lane_mask_t                cur_rdv;
  rn_pkg::lane_mask_t                cur_alloc;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] exp_rd;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] exp_old;

  // retire group of this cycle
  rn_pkg::lane_mask_t                rt_valid;
  rn_pkg::lane_mask_t                rt_flush;
  rn_pkg::lane_mask_t                rt_dead;
  rn_pkg::lane_mask_t                rt_rdv;
  rn_pkg::arch_t [rn_pkg::LANES-1:0] rt_arch;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] rt_new;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] rt_old;

  // group sitting in the retire register
  rn_pkg::lane_mask_t                st_push;
  rn_pkg::lane_mask_t                st_cwr;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] st_pid;
  rn_pkg::arch_t [rn_pkg::LANES-1:0] st_arch;
  rn_pkg::rnid_t [rn_pkg::LANES-1:0] st_new;
  logic                              st_restore;

  logic  draining;   // younger ones of a flush still to retire
  logic  no_front;
  string cur_test;
  int    errors = 0;
  int    checks = 0;
  int    tests = 0;
  int    cycle_cnt = 0;

  rename_unit rename_unit_inst (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_front_valid  (front_valid),
    .i_rs1_arch     (rs1_arch),
    .i_rs2_arch     (rs2_arch),
    .i_rd_valid     (rd_valid),
    .i_rd_arch      (rd_arch),
    .o_ready        (ready),
    .o_rs1_rnid     (rs1_rnid),
    .o_rs2_rnid     (rs2_rnid),
    .o_rd_rnid      (rd_rnid),
    .o_rd_old_rnid  (rd_old_rnid),
    .i_cmt_valid    (cmt_valid),
    .i_cmt_flush    (cmt_flush),
    .i_cmt_dead     (cmt_dead),
    .i_cmt_rd_valid (cmt_rd_valid),
    .i_cmt_rd_arch  (cmt_rd_arch),
    .i_cmt_rd_rnid  (cmt_rd_rnid),
    .i_cmt_old_rnid (cmt_old_rnid)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= 4 * TOTAL_CYCLES) begin
      $display("timeout: run went past %0d cycles without finishing", 4 * TOTAL_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check(input string what, input int exp_val, input int act_val);
    checks++;
    if (exp_val != act_val) begin
      errors++;
      $display("error %s %s: expected %0d, actual %0d", cur_test, what, exp_val, act_val);
    end
  endtask

  // --------------------
  // model update at the clock edge
  // --------------------
  task automatic apply_edge();
    for (int l = 0; l < rn_pkg::LANES; l++) begin
      if (st_push[l]) begin
        free_q[l].push_back(st_pid[l]);
      end
      if (st_cwr[l]) begin
        cmt_map[st_arch[l]] = st_new[l];  // younger lane last
      end
    end
    if (st_restore) begin
      spec_map = cmt_map;
    end
    for (int l = 0; l < rn_pkg::LANES; l++) begin
      if (fired && cur_alloc[l]) begin
        void'(free_q[l].pop_front());
        spec_map[cur_rd[l]] = exp_rd[l];
        fl_arch.push_back(cur_rd[l]);
        fl_new.push_back(exp_rd[l]);
        fl_old.push_back(exp_old[l]);
      end
    end
    // a commit gives back its old id and updates the committed map
    // dead and flushing ones give back the new id
    for (int l = 0; l < rn_pkg::LANES; l++) begin
      st_push[l] = rt_valid[l];  // every in-flight entry has a renamed rd
      st_cwr[l]  = 1'b0;
      st_pid[l]  = rt_new[l];
      if (rt_valid[l] && !rt_dead[l] && !rt_flush[l]) begin
        st_cwr[l] = 1'b1;
        st_pid[l] = rt_old[l];
      end
    end
    st_arch    = rt_arch;
    st_new     = rt_new;
    st_restore = |rt_flush;
    fired      = 1'b0;
  endtask

  task automatic take_head(input int l);
    rt_valid[l] = 1'b1;
    rt_rdv[l]   = 1'b1;
    rt_arch[l]  = fl_arch.pop_front();
    rt_new[l]   = fl_new.pop_front();
    rt_old[l]   = fl_old.pop_front();
  endtask

  task automatic drive_retire(input int mode, input int step);
    int n;
    rt_valid = '0;
    rt_flush = '0;
    rt_dead  = '0;
    rt_rdv   = '0;
    rt_arch  = '0;
    rt_new   = '0;
    rt_old   = '0;
    no_front = draining || (mode == M_DRAIN);
    if (draining) begin
      for (int l = 0; l < rn_pkg::LANES; l++) begin
        if (fl_arch.size() > 0) begin
          take_head(l);
          rt_dead[l] = 1'b1;
        end
      end
      draining = (fl_arch.size() > 0);
    end else if (!(mode == M_STARVE && step < 60)) begin
      n = (mode == M_DRAIN) ? 2 : int'($urandom_range(2, 0));
      if (n > fl_arch.size()) begin
        n = fl_arch.size();
      end
      for (int l = 0; l < n; l++) begin
        take_head(l);
      end
      if (n > 0 && mode != M_DRAIN && $urandom_range(24, 0) == 0) begin
        rt_flush[n-1] = 1'b1;  // youngest of the group flushes
        draining      = 1'b1;
        no_front      = 1'b1;
      end
    end
    cmt_valid    <= rt_valid;
    cmt_flush    <= rt_flush;
    cmt_dead     <= rt_dead;
    cmt_rd_valid <= rt_rdv;
    cmt_rd_arch  <= rt_arch;
    cmt_rd_rnid  <= rt_new;
    cmt_old_rnid <= rt_old;
  endtask

  task automatic drive_front(input int mode);
    if (no_front) begin
      cur_valid = 1'b0;
    end else if (!pending) begin
      cur_valid = (mode == M_IDENT || mode == M_STARVE) || ($urandom_range(3, 0) != 0);
      for (int l = 0; l < rn_pkg::LANES; l++) begin
        cur_rs1[l] = rn_pkg::arch_t'($urandom_range(31, 0));
        cur_rs2[l] = rn_pkg::arch_t'($urandom_range(31, 0));
        cur_rd[l]  = rn_pkg::arch_t'($urandom_range(31, 0));
        cur_rdv[l] = (mode == M_STARVE) || (mode != M_IDENT && $urandom_range(3, 0) != 0);
      end
      if (mode == M_FWD) begin  // lane 1 depends on lane 0
        cur_rdv[0] = 1'b1;
        cur_rd[0]  = rn_pkg::arch_t'($urandom_range(31, 1));
        cur_rs1[1] = cur_rd[0];
        if ($urandom_range(1, 0) != 0) begin
          cur_rs2[1] = cur_rd[0];
        end
        if ($urandom_range(1, 0) != 0) begin
          cur_rd[1] = cur_rd[0];
        end
      end
    end
    front_valid <= cur_valid;
    rs1_arch    <= cur_rs1;
    rs2_arch    <= cur_rs2;
    rd_valid    <= cur_rdv;
    rd_arch     <= cur_rd;
  endtask

  task automatic check_outputs();
    logic          exp_ready;
    rn_pkg::rnid_t exp_rs1;
    rn_pkg::rnid_t exp_rs2;
    exp_ready = (free_q[0].size() > 0) && (free_q[1].size() > 0) && !st_restore;
    check("o_ready", int'(exp_ready), int'(ready));
    fired   = cur_valid & exp_ready;
    pending = cur_valid & ~exp_ready;
    if (fired) begin
      for (int l = 0; l < rn_pkg::LANES; l++) begin
        cur_alloc[l] = cur_rdv[l] && (cur_rd[l] != '0);  // x0 stays put
        exp_rd[l]    = cur_alloc[l] ? free_q[l][0] : '0;
        exp_rs1      = spec_map[cur_rs1[l]];
        exp_rs2      = spec_map[cur_rs2[l]];
        exp_old[l]   = spec_map[cur_rd[l]];
        if (l == 1 && cur_alloc[0]) begin
          if (cur_rd[0] == cur_rs1[1]) exp_rs1 = exp_rd[0];
          if (cur_rd[0] == cur_rs2[1]) exp_rs2 = exp_rd[0];
          if (cur_rd[0] == cur_rd[1])  exp_old[1] = exp_rd[0];
        end
        check("o_rd_rnid", int'(exp_rd[l]), int'(rd_rnid[l]));
        check("o_rs1_rnid", int'(exp_rs1), int'(rs1_rnid[l]));
        check("o_rs2_rnid", int'(exp_rs2), int'(rs2_rnid[l]));
        check("o_rd_old_rnid", int'(exp_old[l]), int'(rd_old_rnid[l]));
      end
    end
  endtask

  task automatic run_test(input string name, input int mode, input int n_steps);
    int start_errs;
    cur_test   = name;
    start_errs = errors;
    for (int s = 0; s < n_steps; s++) begin
      @(posedge clk);
      apply_edge();
      drive_retire(mode, s);
      drive_front(mode);
      @(negedge clk);
      check_outputs();
    end
    tests++;
    $display("test %s finished: %0d cycles, %0d errors", name, n_steps, errors - start_errs);
  endtask

  // every physical id sits once in a free list or the committed map
  task automatic check_id_pool();
    logic [rn_pkg::PHYS_REGS-1:0] seen;
    int                           total;
    seen  = '0;
    total = rn_pkg::ARCH_REGS;
    for (int a = 0; a < rn_pkg::ARCH_REGS; a++) begin
      seen[cmt_map[a]] = 1'b1;
    end
    for (int l = 0; l < rn_pkg::LANES; l++) begin
      for (int i = 0; i < free_q[l].size(); i++) begin
        seen[free_q[l][i]] = 1'b1;
        total++;
      end
    end
    check("in_flight_left", 0, fl_arch.size());
    check("id_total", rn_pkg::PHYS_REGS, total);
    check("id_distinct", rn_pkg::PHYS_REGS, $countones(seen));
  endtask

  initial begin
    void'($urandom(SEED));
    clk          = 1'b0;
    reset_n      = 1'b0;
    front_valid  = 1'b0;
    rs1_arch     = '0;
    rs2_arch     = '0;
    rd_valid     = '0;
    rd_arch      = '0;
    cmt_valid    = '0;
    cmt_flush    = '0;
    cmt_dead     = '0;
    cmt_rd_valid = '0;
    cmt_rd_arch  = '0;
    cmt_rd_rnid  = '0;
    cmt_old_rnid = '0;
    cur_valid    = 1'b0;
    fired        = 1'b0;
    pending      = 1'b0;
    draining     = 1'b0;
    cur_rs1      = '0;
    cur_rs2      = '0;
    cur_rd       = '0;
    cur_rdv      = '0;
    cur_alloc    = '0;
    rt_valid     = '0;
    rt_flush     = '0;
    rt_dead      = '0;
    rt_rdv       = '0;
    rt_arch      = '0;
    rt_new       = '0;
    rt_old       = '0;
    for (int a = 0; a < rn_pkg::ARCH_REGS; a++) begin
      spec_map[a] = rn_pkg::rnid_t'(a);  // identity after reset
      cmt_map[a]  = rn_pkg::rnid_t'(a);
    end
    for (int l = 0; l < rn_pkg::LANES; l++) begin
      for (int i = 0; i < rn_pkg::FLIST_INIT; i++) begin
        free_q[l].push_back(rn_pkg::rnid_t'(rn_pkg::ARCH_REGS + rn_pkg::FLIST_INIT * l + i));
      end
    end
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;

    run_test("reset_identity", M_IDENT, N_IDENT);
    run_test("group_forwarding", M_FWD, N_FWD);
    run_test("random_retire_flush", M_RAND, N_RAND);
    run_test("free_list_starve", M_STARVE, N_STARVE);
    run_test("final_drain", M_DRAIN, N_DRAIN);
    check_id_pool();

    // failed concurrent assertions from the bound checker
    errors += rename_unit_inst.u_props.unique_fails;
    errors += rename_unit_inst.u_props.stall_fails;
    errors += rename_unit_inst.u_props.g_lane[0].preload_fails;
    errors += rename_unit_inst.u_props.g_lane[1].preload_fails;

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/rn_pkg.sv
rtl/rn_retire_if.sv
rtl/rn_freelist.sv
rtl/rn_map_table.sv
rtl/rn_commit_map.sv
rtl/rn_retire_stage.sv
rtl/rn_group_bypass.sv
rtl/rename_unit.sv
test/rename_unit_props.sv
test/tb_rename_unit.sv

//--- Makefile
# Verilator build and run for the rename unit testbench

VERILATOR ?= verilator
TOP       ?= tb_rename_unit
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_STR  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
